// ==== vlog.f ====
elinkPkg.sv
frameBuffer.sv
crcAccum.sv
frameCheck.sv
elinkFrameRx.sv
elinkFrameRx_props.sv
tb_elinkFrameRx.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_elinkFrameRx
FILELIST = vlog.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
FAIL_MSG = Some tests failed
PASS_MSG = All tests passed

SRCS = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb_elinkFrameRx.sv ====
/*
   tb_elinkFrameRx
   testbench for the e-link frame receiver. Sends payload and check
   bytes, keeps a reference model of the slots, CRC, latched message
   and error counter, and checks the outputs with concurrent assertions
*/
`timescale 1ns/10ps
`default_nettype none

module tb_elinkFrameRx
   import elinkPkg::*;
;

   logic                 clk;
   logic                 rst;
   logic [BYTE_W-1:0]    byteIn;
   logic                 byteEn;
   logic [ADDR_W-1:0]    addr;
   logic [FRAME_W-1:0]   frameOut;
   logic                 frameValid;
   logic                 frameError;
   logic [ERR_CNT_W-1:0] errorCount;

   // reference model state
   logic [BYTE_W-1:0]    modelSlot [10];
   logic [BYTE_W-1:0]    modelCrc;
   logic [FRAME_W-1:0]   modelFrame;    // last accepted message
   logic [ERR_CNT_W-1:0] modelErrCnt;

   // expected outputs for the latest check byte
   logic                 expValid;
   logic                 expError;
   logic [FRAME_W-1:0]   expFrame;
   logic [ERR_CNT_W-1:0] expErrCnt;

   logic  chkStrobe;
   int    seed;
   int    errors;
   int    errStart;
   int    testsRun;
   int    testsFailed;
   string testName;

   elinkFrameRx UUT (
      .clk        (clk),
      .rst        (rst),
      .byteIn     (byteIn),
      .byteEn     (byteEn),
      .addr       (addr),
      .frameOut   (frameOut),
      .frameValid (frameValid),
      .frameError (frameError),
      .errorCount (errorCount)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   assign chkStrobe = byteEn && (addr == SLOT_CHK);

   // outputs straight out of reset
   resetValues: assert property (@(posedge clk)
      $rose(rst) |-> (frameOut == '0) && (errorCount == '0) && !frameValid && !frameError)
   else
   begin
      errors++;
      $display("** Error %s: reset outputs expected 0/0/0/0, actual %h/%h/%b/%b", testName,
               $sampled(frameOut), $sampled(errorCount), $sampled(frameValid),
               $sampled(frameError));
   end

   pulseResult: assert property (@(posedge clk) disable iff (!rst)
      chkStrobe |=> (frameValid == expValid) && (frameError == expError))
   else
   begin
      errors++;
      $display("** Error %s: valid/error expected %b/%b, actual %b/%b", testName,
               expValid, expError, $sampled(frameValid), $sampled(frameError));
   end

   frameResult: assert property (@(posedge clk) disable iff (!rst)
      chkStrobe |=> frameOut == expFrame)
   else
   begin
      errors++;
      $display("** Error %s: frameOut expected %h, actual %h", testName, expFrame,
               $sampled(frameOut));
   end

   countResult: assert property (@(posedge clk) disable iff (!rst)
      chkStrobe |=> errorCount == expErrCnt)
   else
   begin
      errors++;
      $display("** Error %s: errorCount expected %0d, actual %0d", testName, expErrCnt,
               $sampled(errorCount));
   end

   // CRC-8 one data bit at a time, MSB first
   function automatic logic [BYTE_W-1:0] crcOfByte(input logic [BYTE_W-1:0] crcIn,
                                                   input logic [BYTE_W-1:0] data);
      logic [BYTE_W-1:0] crc;
      logic              feedback;
      int                i;
      crc = crcIn;
      for (i = BYTE_W - 1; i >= 0; i--)
      begin
         feedback = crc[BYTE_W-1] ^ data[i];
         crc      = {crc[BYTE_W-2:0], 1'b0};
         if (feedback)
            crc = crc ^ CRC_POLY;
      end
      return crc;
   endfunction

   // slots 0..8 whole, top nibble of slot 9
   function automatic logic [FRAME_W-1:0] packFrame();
      logic [FRAME_W-1:0] f;
      int                 k;
      f = '0;
      for (k = 0; k < 9; k++)
         f = {f[FRAME_W-BYTE_W-1:0], modelSlot[k]};
      f = {f[FRAME_W-5:0], modelSlot[9][BYTE_W-1:BYTE_W/2]};
      return f;
   endfunction

   function automatic logic [ADDR_W-1:0] unusedAddr();
      int u;
      u = {$random(seed)} % 21;   // 0, 1 or 13..31
      if (u < 2)
         return ADDR_W'(u);
      return ADDR_W'(u + 11);
   endfunction

   task automatic driveByte(input logic [ADDR_W-1:0] a, input logic [BYTE_W-1:0] d,
                            input logic en);
      @(posedge clk);
      addr   <= a;
      byteIn <= d;
      byteEn <= en;
   endtask

   task automatic resetModel();
      int k;
      for (k = 0; k < 10; k++)
         modelSlot[k] = '0;
      modelCrc    = '0;
      modelFrame  = '0;
      modelErrCnt = '0;
   endtask

   task automatic applyReset();
      @(posedge clk);
      rst    <= 1'b0;
      byteEn <= 1'b0;
      repeat (16) @(posedge clk);
      rst <= 1'b1;
      resetModel();
   endtask

   task automatic sendPayload(input int idx, input logic [BYTE_W-1:0] data);
      driveByte(ADDR_W'(int'(SLOT_B0) + idx), data, 1'b1);
      if (idx == 0)
         modelCrc = '0;   // first slot restarts the checksum
      modelCrc       = crcOfByte(modelCrc, data);
      modelSlot[idx] = data;
   endtask

   task automatic waitResult();
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < 8)
      begin
         @(negedge clk);
         seen = frameValid || frameError;
         cycles++;
      end
      if (!seen)
      begin
         errors++;
         $display("test %s: no result pulse within 8 cycles of the check byte", testName);
      end
      @(negedge clk);   // output checks sample on the edge after the pulse
   endtask

   task automatic sendCheck(input logic [BYTE_W-1:0] chk);
      logic good;
      good = (chk == modelCrc);
      if (good)
         modelFrame = packFrame();
      else if (modelErrCnt != '1)
         modelErrCnt++;
      driveByte(SLOT_CHK, chk, 1'b1);
      expValid  <= good;
      expError  <= !good;
      expFrame  <= modelFrame;
      expErrCnt <= modelErrCnt;
      driveByte('0, '0, 1'b0);
      waitResult();
   endtask

   task automatic sendMessage(input logic corrupt, input logic withGaps);
      logic [BYTE_W-1:0] bad;
      int                i;
      for (i = 0; i < 10; i++)
      begin
         sendPayload(i, BYTE_W'($random(seed)));
         if (withGaps)
         begin
            driveByte(ADDR_W'(int'(SLOT_B0) + i), BYTE_W'($random(seed)), 1'b0);
            driveByte(unusedAddr(), BYTE_W'($random(seed)), 1'b1);
         end
      end
      bad = BYTE_W'($random(seed));
      if (bad == '0)
         bad = 8'h01;
      sendCheck(corrupt ? (modelCrc ^ bad) : modelCrc);
   endtask

   task automatic startTest(input string name);
      testName = name;
      errStart = errors;
   endtask

   task automatic reportTest();
      testsRun++;
      if (errors == errStart)
         $display("test %-24s passed", testName);
      else
      begin
         testsFailed++;
         $display("test %-24s FAILED, %0d errors", testName, errors - errStart);
      end
   endtask

   initial
   begin
      int i;
      seed = 32'h2f34;
      rst = 1'b0;
      byteIn = '0;
      byteEn = 1'b0;
      addr = '0;
      expValid = 1'b0;
      expError = 1'b0;
      expFrame = '0;
      expErrCnt = '0;
      errors = 0;
      errStart = 0;
      testsRun = 0;
      testsFailed = 0;
      testName = "reset values";
      resetModel();
      repeat (16) @(posedge clk);
      rst <= 1'b1;

      startTest("reset values");
      repeat (3) driveByte('0, '0, 1'b0);
      reportTest();
      startTest("good message");
      sendMessage(1'b0, 1'b0);
      reportTest();
      startTest("bad check byte");
      sendMessage(1'b1, 1'b0);
      reportTest();
      startTest("unused slots and gaps");
      sendMessage(1'b0, 1'b1);
      sendMessage(1'b0, 1'b0);
      reportTest();
      startTest("CRC restart");
      for (i = 0; i < 5; i++)
         sendPayload(i, BYTE_W'($random(seed)));   // abandoned half message
      sendMessage(1'b0, 1'b0);
      reportTest();
      startTest("random messages");
      for (i = 0; i < 6; i++)
         sendMessage(1'(($random(seed)) & 1), 1'(($random(seed)) & 1));
      reportTest();
      startTest("check without payload");
      applyReset();
      sendCheck(8'h00);
      sendCheck(8'h5a);
      reportTest();

      $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== elinkFrameRx_props.sv ====
/*
   elinkFrameRx_props
   protocol checks on the receiver outputs: result pulses,
   error counter and the latched message
*/
`timescale 1ns/10ps
`default_nettype none

module elinkFrameRx_props
   import elinkPkg::*;
(
   input logic                 clk,
   input logic                 rst,
   input logic                 byteEn,
   input logic [ADDR_W-1:0]    addr,
   input logic [FRAME_W-1:0]   frameOut,
   input logic                 frameValid,
   input logic                 frameError,
   input logic [ERR_CNT_W-1:0] errorCount
);

   logic chkSeen;   // check byte on the bus

   assign chkSeen = byteEn && (addr == SLOT_CHK);

   pulsesExclusive: assert property (@(posedge clk) disable iff (!rst)
      !(frameValid && frameError))
      else $error("frameValid and frameError high together");

   validAfterCheck: assert property (@(posedge clk) disable iff (!rst)
      frameValid |-> $past(chkSeen))
      else $error("frameValid without a check byte one cycle before");

   errorAfterCheck: assert property (@(posedge clk) disable iff (!rst)
      frameError |-> $past(chkSeen))
      else $error("frameError without a check byte one cycle before");

   // counter only moves up outside reset
   countMonotonic: assert property (@(posedge clk) disable iff (!rst)
      $past(rst) |-> errorCount >= $past(errorCount))
      else $error("errorCount decreased");

   frameOutStable: assert property (@(posedge clk) disable iff (!rst)
      $past(rst) && (frameOut != $past(frameOut)) |-> frameValid && $past(chkSeen))
      else $error("frameOut changed without a frameValid pulse");

endmodule

bind elinkFrameRx elinkFrameRx_props uProps (
   .clk        (clk),
   .rst        (rst),
   .byteEn     (byteEn),
   .addr       (addr),
   .frameOut   (frameOut),
   .frameValid (frameValid),
   .frameError (frameError),
   .errorCount (errorCount)
);

`default_nettype wire

// ==== elinkFrameRx.sv ====
/*
   elinkFrameRx
   receive side of the CAN message e-link. The byte stream feeds
   the slot store, the CRC accumulator and the frame checker in
   parallel; the checker drives every output
*/
`timescale 1ns/10ps
`default_nettype none

module elinkFrameRx
   import elinkPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,          // active low
   input  logic [BYTE_W-1:0]    byteIn,
   input  logic                 byteEn,
   input  logic [ADDR_W-1:0]    addr,
   output logic [FRAME_W-1:0]   frameOut,
   output logic                 frameValid,
   output logic                 frameError,
   output logic [ERR_CNT_W-1:0] errorCount
);

   logic [FRAME_W-1:0] bufFrame;
   logic [BYTE_W-1:0]  crcValue;

   frameBuffer uBuf (
      .clk      (clk),
      .rst      (rst),
      .byteIn   (byteIn),
      .byteEn   (byteEn),
      .addr     (addr),
      .bufFrame (bufFrame)
   );

   crcAccum uCrc (
      .clk      (clk),
      .rst      (rst),
      .byteIn   (byteIn),
      .byteEn   (byteEn),
      .addr     (addr),
      .crcValue (crcValue)
   );

   frameCheck uCheck (
      .clk        (clk),
      .rst        (rst),
      .byteIn     (byteIn),
      .byteEn     (byteEn),
      .addr       (addr),
      .bufFrame   (bufFrame),
      .crcValue   (crcValue),
      .frameOut   (frameOut),
      .frameValid (frameValid),
      .frameError (frameError),
      .errorCount (errorCount)
   );

endmodule

`default_nettype wire

// ==== frameCheck.sv ====
/*
   frameCheck
   compares the check byte with the running CRC. A match latches
   the buffered message and pulses frameValid, a mismatch pulses
   frameError and bumps a saturating error counter
*/
`timescale 1ns/10ps
`default_nettype none

module frameCheck
   import elinkPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,          // active low
   input  logic [BYTE_W-1:0]    byteIn,
   input  logic                 byteEn,
   input  logic [ADDR_W-1:0]    addr,
   input  logic [FRAME_W-1:0]   bufFrame,     // live packing from the store
   input  logic [BYTE_W-1:0]    crcValue,     // CRC over the bytes so far
   output logic [FRAME_W-1:0]   frameOut,
   output logic                 frameValid,
   output logic                 frameError,
   output logic [ERR_CNT_W-1:0] errorCount
);

   logic chkStrobe;   // check byte present this cycle
   logic crcMatch;
   logic errSat;      // counter pinned at all ones

   assign chkStrobe = byteEn && (slotAddr_e'(addr) == SLOT_CHK);
   assign crcMatch  = (byteIn == crcValue);
   assign errSat    = &errorCount;

   // result pulses, one cycle after the check strobe
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         frameValid <= 1'b0;
         frameError <= 1'b0;
      end
      else
      begin
         frameValid <= chkStrobe && crcMatch;
         frameError <= chkStrobe && !crcMatch;
      end
   end

   // good message held until the next good one
   always_ff @(posedge clk)
   begin
      if (!rst)
         frameOut <= '0;
      else if (chkStrobe && crcMatch)
         frameOut <= bufFrame;
   end

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         errorCount <= '0;
      end
      else if (chkStrobe && !crcMatch && !errSat)
      begin
         errorCount <= errorCount + 1'b1;   // stops at 255
      end
   end

endmodule

`default_nettype wire

// ==== crcAccum.sv ====
/*
   crcAccum
   running CRC-8 over the payload bytes in arrival order.
   A strobe at the first payload slot seeds the step from zero,
   so every new message starts a fresh checksum
*/
`timescale 1ns/10ps
`default_nettype none

module crcAccum
   import elinkPkg::*;
(
   input  logic              clk,
   input  logic              rst,        // active low
   input  logic [BYTE_W-1:0] byteIn,
   input  logic              byteEn,
   input  logic [ADDR_W-1:0] addr,
   output logic [BYTE_W-1:0] crcValue
);

   logic              isPayload;   // addr is one of the ten data slots
   logic [BYTE_W-1:0] crcSeed;
   logic [BYTE_W-1:0] crcNext;

   // one byte through the CRC shift register, MSB first
   function automatic logic [BYTE_W-1:0] crcStep(input logic [BYTE_W-1:0] crcIn,
                                                 input logic [BYTE_W-1:0] data);
      logic [BYTE_W-1:0] crc;
      int                bitIdx;
      crc = crcIn ^ data;
      for (bitIdx = 0; bitIdx < BYTE_W; bitIdx++)
      begin
         if (crc[BYTE_W-1])
            crc = (crc << 1) ^ CRC_POLY;
         else
            crc = crc << 1;
      end
      return crc;
   endfunction

   always_comb
   begin
      case (slotAddr_e'(addr))
         SLOT_B0, SLOT_B1, SLOT_B2, SLOT_B3, SLOT_B4,
         SLOT_B5, SLOT_B6, SLOT_B7, SLOT_B8, SLOT_B9:
            isPayload = 1'b1;
         default:
            isPayload = 1'b0;
      endcase
   end

   // first slot restarts, even after an abandoned message
   assign crcSeed = (slotAddr_e'(addr) == SLOT_B0) ? '0 : crcValue;
   assign crcNext = crcStep(crcSeed, byteIn);

   always_ff @(posedge clk)
   begin
      if (!rst)
         crcValue <= '0;
      else if (byteEn && isPayload)
         crcValue <= crcNext;   // check byte and unused slots hold
   end

endmodule

`default_nettype wire

// ==== frameBuffer.sv ====
/*
   frameBuffer
   addressed byte store of the e-link receive path. Ten payload
   slots are written by the byte strobe and packed live into a
   CAN message: a 12-bit identifier field and eight data bytes
*/
`timescale 1ns/10ps
`default_nettype none

module frameBuffer
   import elinkPkg::*;
(
   input  logic               clk,
   input  logic               rst,        // active low
   input  logic [BYTE_W-1:0]  byteIn,
   input  logic               byteEn,     // one cycle per byte
   input  logic [ADDR_W-1:0]  addr,
   output logic [FRAME_W-1:0] bufFrame
);

   // id is 11 bits, kept as three hex digits in slotB0 and the top of slotB1
   logic [BYTE_W-1:0] slotB0;
   logic [BYTE_W-1:0] slotB1;
   logic [BYTE_W-1:0] slotB2;
   logic [BYTE_W-1:0] slotB3;
   logic [BYTE_W-1:0] slotB4;
   logic [BYTE_W-1:0] slotB5;
   logic [BYTE_W-1:0] slotB6;
   logic [BYTE_W-1:0] slotB7;
   logic [BYTE_W-1:0] slotB8;
   logic [BYTE_W-1:0] slotB9;

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         slotB0 <= '0;
         slotB1 <= '0;
         slotB2 <= '0;
         slotB3 <= '0;
         slotB4 <= '0;
         slotB5 <= '0;
         slotB6 <= '0;
         slotB7 <= '0;
         slotB8 <= '0;
         slotB9 <= '0;
      end
      else if (byteEn)
      begin
         // one slot per strobe, same edge
         case (slotAddr_e'(addr))
            SLOT_B0:
               slotB0 <= byteIn;
            SLOT_B1:
               slotB1 <= byteIn;
            SLOT_B2:
               slotB2 <= byteIn;
            SLOT_B3:
               slotB3 <= byteIn;
            SLOT_B4:
               slotB4 <= byteIn;
            SLOT_B5:
               slotB5 <= byteIn;
            SLOT_B6:
               slotB6 <= byteIn;
            SLOT_B7:
               slotB7 <= byteIn;
            SLOT_B8:
               slotB8 <= byteIn;
            SLOT_B9:
               slotB9 <= byteIn;
            default:
            begin
               // check byte and unused slots leave the store alone
            end
         endcase
      end
   end

   // 9 full bytes, then only the upper nibble of the last one
   assign bufFrame = {slotB0,
                      slotB1,
                      slotB2,
                      slotB3,
                      slotB4,
                      slotB5,
                      slotB6,
                      slotB7,
                      slotB8,
                      slotB9[BYTE_W-1:BYTE_W/2]};

endmodule

`default_nettype wire

// ==== elinkPkg.sv ====
/*
   elink receive package
   slot addresses of the incoming byte stream, field widths
   and the CRC-8 polynomial shared by the receive blocks
*/
`default_nettype none

package elinkPkg;

   // byte stream geometry
   localparam int BYTE_W    = 8;
   localparam int ADDR_W    = 5;
   localparam int FRAME_W   = 76;   // 12-bit id field plus eight data bytes
   localparam int ERR_CNT_W = 8;    // saturating bad frame counter

   // CRC-8, x^8 + x^2 + x + 1, MSB first
   localparam logic [BYTE_W-1:0] CRC_POLY = 8'h07;

   // slot addresses carried with each byte strobe
   typedef enum logic [ADDR_W-1:0] {
      SLOT_B0  = 5'd2,    // first identifier digits, restarts the CRC
      SLOT_B1  = 5'd3,
      SLOT_B2  = 5'd4,
      SLOT_B3  = 5'd5,
      SLOT_B4  = 5'd6,
      SLOT_B5  = 5'd7,
      SLOT_B6  = 5'd8,
      SLOT_B7  = 5'd9,
      SLOT_B8  = 5'd10,
      SLOT_B9  = 5'd11,   // last payload byte, low nibble not used
      SLOT_CHK = 5'd12    // CRC check byte, closes the message
   } slotAddr_e;

   // all other slot values are unused and ignored by the receiver

endpackage

`default_nettype wire
